// ==== include/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Number of opcodes in the ISA, sets the opcode field width
`define CPU_NUM_OPS 16

`endif

// ==== verilog/isa_pkg.sv ====
`default_nettype none

`include "cpu_defs.svh"

package isa_pkg;

    localparam int DATA_W = 16;                      // Datapath width
    localparam int REG_W  = 4;                       // Sixteen architectural registers
    localparam int OP_W   = $clog2(`CPU_NUM_OPS);    // Opcode field width

    // Flag register bit positions
    localparam int FLAG_Z = 2;                       // Zero
    localparam int FLAG_V = 1;                       // Signed overflow
    localparam int FLAG_N = 0;                       // Negative

    typedef logic [DATA_W-1:0] word_t;               // Data word
    typedef logic [REG_W-1:0]  reg_idx_t;            // Register number
    typedef logic [2:0]        flags_t;              // {Z, V, N}

    typedef enum logic [OP_W-1:0] {
        ADD    = 4'h0,                               // Saturating add
        SUB    = 4'h1,                               // Saturating subtract
        XOR    = 4'h2,
        RED    = 4'h3,                               // Reduction add of bytes
        SLL    = 4'h4,
        SRA    = 4'h5,
        ROR    = 4'h6,
        PADDSB = 4'h7,                               // Nibble-wise saturating add
        LW     = 4'h8,
        SW     = 4'h9,
        LLB    = 4'hA,                               // Load low byte
        LHB    = 4'hB,                               // Load high byte
        B      = 4'hC,                               // Conditional branch
        BR     = 4'hD,                               // Branch to register
        PCS    = 4'hE,                               // Save PC
        HLT    = 4'hF
    } opcode_e;

endpackage

`default_nettype wire

// ==== verilog/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;
    import isa_pkg::*;

    // Operand source picked by forwarding
    typedef enum logic [1:0] {
        FWD_NONE  = 2'b00,                           // Use the ID/EX data
        FWD_EXMEM = 2'b01,                           // Result one instruction ahead
        FWD_MEMWB = 2'b10                            // Write-back value two ahead
    } fwd_sel_e;

    // ID/EX bundle, 72 bits
    typedef struct packed {
        logic     valid;
        word_t    rr1_data;                          // Source 1 value from decode
        word_t    rr2_data;                          // Source 2 value from decode
        word_t    imm_value;                         // Extended immediate
        reg_idx_t rr1_reg;
        reg_idx_t rr2_reg;
        reg_idx_t wr_reg;                            // Destination
        opcode_e  alu_op;
        logic     alu_src;                           // Operand B from immediate
        logic     mem_to_reg;                        // Write back load data
        logic     reg_write;
        logic     mem_write;
        logic     mem_read;
        logic     flag_enable;                       // Op may update flags
        logic     halt;
    } id_ex_t;

    // EX/MEM bundle, 50 bits
    typedef struct packed {
        logic     valid;
        reg_idx_t rr1_reg;
        reg_idx_t rr2_reg;
        word_t    alu_result;                        // Also the memory address
        word_t    store_data;                        // Forwarded rr2 value
        reg_idx_t wr_reg;
        logic     mem_write;
        logic     mem_to_reg;
        logic     reg_write;
        logic     halt;
        logic     mem_read;
    } ex_mem_t;

    // MEM/WB bundle, 23 bits
    typedef struct packed {
        logic     valid;
        reg_idx_t wr_reg;
        word_t    wb_data;                           // Load data or ALU result
        logic     reg_write;
        logic     halt;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== verilog/alu_arith.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_arith import isa_pkg::*; (
    input  word_t   a,                               // Operand A
    input  word_t   b,                               // Operand B or immediate
    input  opcode_e op,
    output word_t   result,
    output logic    ovf                              // Set when ADD/SUB saturates
);

    logic [DATA_W:0]   sum_ext;                      // Sign-extended sum
    logic [DATA_W:0]   diff_ext;                     // Sign-extended difference
    logic              sum_ovf;
    logic              diff_ovf;
    logic signed [9:0] red_sum;                      // Four signed bytes need 10 bits
    word_t             padd;

    // Clamp a 17-bit signed value to the 16-bit range
    function automatic word_t sat_word(input logic [DATA_W:0] s);
        if (s[DATA_W] != s[DATA_W-1]) begin
            return s[DATA_W] ? {1'b1, {(DATA_W-1){1'b0}}} : {1'b0, {(DATA_W-1){1'b1}}};
        end
        return s[DATA_W-1:0];
    endfunction

    // 4-bit signed add with saturation
    function automatic logic [3:0] sat_nib(input logic [3:0] x, input logic [3:0] y);
        logic [4:0] s;
        s = {x[3], x} + {y[3], y};
        if (s[4] != s[3]) begin
            return s[4] ? 4'h8 : 4'h7;               // Most negative or most positive
        end
        return s[3:0];
    endfunction

    assign sum_ext  = {a[DATA_W-1], a} + {b[DATA_W-1], b};
    assign diff_ext = {a[DATA_W-1], a} - {b[DATA_W-1], b};
    assign sum_ovf  = sum_ext[DATA_W] ^ sum_ext[DATA_W-1];   // Top two bits disagree
    assign diff_ovf = diff_ext[DATA_W] ^ diff_ext[DATA_W-1];

    // RED sums the two bytes of each operand as signed values
    assign red_sum = $signed(a[15:8]) + $signed(a[7:0]) + $signed(b[15:8]) + $signed(b[7:0]);

    assign padd = {sat_nib(a[15:12], b[15:12]), sat_nib(a[11:8], b[11:8]),
                   sat_nib(a[7:4], b[7:4]), sat_nib(a[3:0], b[3:0])};

    always_comb begin
        ovf    = 1'b0;
        result = '0;                                 // Shifts and control ops give 0
        case (op)
            ADD: begin
                result = sat_word(sum_ext);
                ovf    = sum_ovf;
            end
            SUB: begin
                result = sat_word(diff_ext);
                ovf    = diff_ovf;
            end
            XOR:     result = a ^ b;
            RED:     result = {{(DATA_W-10){red_sum[9]}}, red_sum};  // Sign extend
            PADDSB:  result = padd;
            LW, SW:  result = {a[DATA_W-1:1], 1'b0} + b;    // Word aligned base plus offset
            LLB:     result = {a[15:8], b[7:0]};            // Keep high byte
            LHB:     result = {b[7:0], a[7:0]};             // Keep low byte
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/alu_shift.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_shift import isa_pkg::*; (
    input  word_t      a,                            // Value to shift
    input  logic [3:0] amount,                       // Shift distance 0..15
    input  opcode_e    op,
    output word_t      result
);

    logic [2*DATA_W-1:0] rot_ext;                    // Doubled word for rotate
    word_t               sll_res;
    word_t               sra_res;

    assign sll_res = a << amount;                    // Zero fill from the right
    assign sra_res = $signed(a) >>> amount;          // Sign fill from the left
    assign rot_ext = {a, a} >> amount;               // Low half is the rotated word

    always_comb begin
        case (op)
            SLL:     result = sll_res;
            SRA:     result = sra_res;
            ROR:     result = rot_ext[DATA_W-1:0];
            default: result = '0;                    // Not a shift op
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/forward_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module forward_unit import isa_pkg::*, pipe_pkg::*; (
    input  id_ex_t   id_ex,                          // Instruction entering EX
    input  ex_mem_t  ex_mem,                         // One instruction ahead
    input  mem_wb_t  mem_wb,                         // Two instructions ahead
    output fwd_sel_e fwd_sel_a,
    output fwd_sel_e fwd_sel_b,
    output word_t    fwd_data_a,
    output word_t    fwd_data_b
);

    // Choose the youngest writer of src, loads in EX/MEM have no data yet
    function automatic fwd_sel_e pick_src(input reg_idx_t src, input ex_mem_t em,
                                          input mem_wb_t mw);
        if (src == '0) begin
            return FWD_NONE;                         // R0 never forwards
        end
        if (em.valid && em.reg_write && !em.mem_read && em.wr_reg == src) begin
            return FWD_EXMEM;
        end
        if (mw.valid && mw.reg_write && mw.wr_reg == src) begin
            return FWD_MEMWB;
        end
        return FWD_NONE;
    endfunction

    // Value that goes with a select
    function automatic word_t pick_data(input fwd_sel_e sel, input ex_mem_t em,
                                        input mem_wb_t mw);
        case (sel)
            FWD_EXMEM: return em.alu_result;
            FWD_MEMWB: return mw.wb_data;
            default:   return '0;
        endcase
    endfunction

    assign fwd_sel_a  = pick_src(id_ex.rr1_reg, ex_mem, mem_wb);
    assign fwd_sel_b  = pick_src(id_ex.rr2_reg, ex_mem, mem_wb);
    assign fwd_data_a = pick_data(fwd_sel_a, ex_mem, mem_wb);
    assign fwd_data_b = pick_data(fwd_sel_b, ex_mem, mem_wb);

endmodule

`default_nettype wire

// ==== verilog/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,                          // Hold all state
    input  id_ex_t   id_ex,                          // From ID/EX register
    input  fwd_sel_e fwd_sel_a,                      // From forwarding unit
    input  fwd_sel_e fwd_sel_b,
    input  word_t    fwd_data_a,
    input  word_t    fwd_data_b,
    output ex_mem_t  ex_mem,                         // EX/MEM register
    output flags_t   flags                           // {Z, V, N}
);

    word_t   op_a;
    word_t   op_b;
    word_t   store_data;
    word_t   arith_res;
    word_t   shift_res;
    word_t   alu_result;
    logic    arith_ovf;
    logic    is_shift;
    logic    vn_update;                              // Op writes V and N
    ex_mem_t ex_mem_next;

    // Operand A is forwarded or taken from decode
    assign op_a = (fwd_sel_a != FWD_NONE) ? fwd_data_a : id_ex.rr1_data;

    // Forwarded B wins over the immediate
    assign op_b = (fwd_sel_b != FWD_NONE) ? fwd_data_b :
                  (id_ex.alu_src ? id_ex.imm_value : id_ex.rr2_data);

    // Store data never takes the immediate
    assign store_data = (fwd_sel_b != FWD_NONE) ? fwd_data_b : id_ex.rr2_data;

    alu_arith u_alu_arith (
        .a      (op_a),
        .b      (op_b),
        .op     (id_ex.alu_op),
        .result (arith_res),
        .ovf    (arith_ovf)
    );

    alu_shift u_alu_shift (
        .a      (op_a),
        .amount (op_b[3:0]),                         // Low nibble of B is the distance
        .op     (id_ex.alu_op),
        .result (shift_res)
    );

    assign is_shift   = id_ex.alu_op inside {SLL, SRA, ROR};
    assign alu_result = is_shift ? shift_res : arith_res;
    assign vn_update  = id_ex.alu_op inside {ADD, SUB};

    always_comb begin
        ex_mem_next.valid      = id_ex.valid;
        ex_mem_next.rr1_reg    = id_ex.rr1_reg;
        ex_mem_next.rr2_reg    = id_ex.rr2_reg;
        ex_mem_next.alu_result = alu_result;
        ex_mem_next.store_data = store_data;
        ex_mem_next.wr_reg     = id_ex.wr_reg;
        ex_mem_next.mem_write  = id_ex.mem_write;
        ex_mem_next.mem_to_reg = id_ex.mem_to_reg;
        ex_mem_next.reg_write  = id_ex.reg_write;
        ex_mem_next.halt       = id_ex.halt;
        ex_mem_next.mem_read   = id_ex.mem_read;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;                    // Payload left as is
            flags        <= '0;
        end else if (!stall) begin
            ex_mem <= ex_mem_next;
            if (id_ex.valid && id_ex.flag_enable) begin
                flags[FLAG_Z] <= (alu_result == '0);
                if (vn_update) begin
                    flags[FLAG_V] <= arith_ovf;
                    flags[FLAG_N] <= alu_result[DATA_W-1];  // Sign of result
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,                           // Hold the register
    input  ex_mem_t ex_mem,                          // Memory stage bundle
    input  word_t   mem_rdata,                       // Load data for EX/MEM item
    output mem_wb_t mem_wb                           // Register write port
);

    word_t wb_data_next;

    // Loads write back memory data, everything else the ALU result
    assign wb_data_next = ex_mem.mem_to_reg ? mem_rdata : ex_mem.alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.valid <= 1'b0;
        end else if (!stall) begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.wr_reg    <= ex_mem.wr_reg;
            mem_wb.wb_data   <= wb_data_next;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.halt      <= ex_mem.halt;     // Halt reaches write-back
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ex_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_pipeline import isa_pkg::*, pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,                           // Common pipeline stall
    input  id_ex_t  id_ex,                           // Decode output
    input  word_t   mem_rdata,                       // Load data from memory
    output ex_mem_t ex_mem,                          // Memory request
    output mem_wb_t mem_wb,                          // Write-back port
    output flags_t  flags
);

    fwd_sel_e fwd_sel_a;
    fwd_sel_e fwd_sel_b;
    word_t    fwd_data_a;
    word_t    fwd_data_b;

    forward_unit u_forward_unit (
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),                        // Registered stage outputs
        .mem_wb     (mem_wb),
        .fwd_sel_a  (fwd_sel_a),
        .fwd_sel_b  (fwd_sel_b),
        .fwd_data_a (fwd_data_a),
        .fwd_data_b (fwd_data_b)
    );

    execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .id_ex      (id_ex),
        .fwd_sel_a  (fwd_sel_a),
        .fwd_sel_b  (fwd_sel_b),
        .fwd_data_a (fwd_data_a),
        .fwd_data_b (fwd_data_b),
        .ex_mem     (ex_mem),
        .flags      (flags)
    );

    mem_wb_stage u_mem_wb_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .ex_mem    (ex_mem),
        .mem_rdata (mem_rdata),
        .mem_wb    (mem_wb)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 10;                // 20 ns clock
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                               // Released just after the 8th edge
    end

endmodule

`default_nettype wire

// ==== bench/tb_ex_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_ex_pipeline import isa_pkg::*, pipe_pkg::*; ();

    localparam int NUM_TESTS = 2000;                 // Random cycles after reset
    localparam int TIMEOUT   = NUM_TESTS + 100;

    logic    clk;
    logic    rst_n;
    logic    stall;
    id_ex_t  id_ex;
    word_t   mem_rdata;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    flags_t  flags;

    integer  seed;
    int      errors;
    int      checks;
    int      cyc;
    int      cycles = 0;                             // Timeout counter
    word_t   rf_now [16];                            // Register state in program order
    word_t   rf_dec [16];                            // Registers as decode reads them
    ex_mem_t exp_em;                                 // Expected stage contents
    mem_wb_t exp_wb;
    flags_t  exp_flags;
    opcode_e em_op;                                  // Opcode now in EX/MEM

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ex_pipeline DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .id_ex     (id_ex),
        .mem_rdata (mem_rdata),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb),
        .flags     (flags)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Run stopped: no result after %0d cycles", TIMEOUT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Signed nibble add clamped to -8..7
    function automatic logic [3:0] nib_add(input logic [3:0] x, input logic [3:0] y);
        int s;
        s = int'($signed(x)) + int'($signed(y));
        s = (s > 7) ? 7 : ((s < -8) ? -8 : s);
        return s[3:0];
    endfunction

    // Reference ALU with ovf set when ADD/SUB clamps
    function automatic word_t model_alu(input opcode_e op, input word_t a, input word_t b,
                                        output logic ovf);
        logic signed [15:0] sa;
        int                 s;
        int                 n;
        sa  = a;
        n   = b[3:0];                                // Shift distance
        ovf = 1'b0;
        case (op)
            ADD, SUB: begin
                s   = (op == ADD) ? int'(sa) + int'($signed(b)) : int'(sa) - int'($signed(b));
                ovf = (s > 32767) || (s < -32768);
                s   = (s > 32767) ? 32767 : ((s < -32768) ? -32768 : s);
                return s[15:0];
            end
            XOR: return a ^ b;
            RED: begin
                s = int'($signed(a[15:8])) + int'($signed(a[7:0]))
                    + int'($signed(b[15:8])) + int'($signed(b[7:0]));
                return s[15:0];                      // Low half of int is sign extended
            end
            SLL:     return a << n;
            SRA:     return sa >>> n;
            ROR:     return (a >> n) | (a << (16 - n));
            PADDSB:  return {nib_add(a[15:12], b[15:12]), nib_add(a[11:8], b[11:8]),
                             nib_add(a[7:4], b[7:4]), nib_add(a[3:0], b[3:0])};
            LW, SW:  return (a & 16'hfffe) + b;
            LLB:     return {a[15:8], b[7:0]};
            LHB:     return {b[7:0], a[7:0]};
            default: return '0;
        endcase
    endfunction

    // Small register set steered off a load destination still in EX/MEM
    function automatic reg_idx_t pick_reg(input logic ld_busy, input reg_idx_t ld_dst);
        reg_idx_t r;
        r = $random(seed) & 3;
        if (ld_busy && r == ld_dst) begin
            r = r ^ 1;
        end
        return r;
    endfunction

    // An older writer of r is in flight and can be forwarded
    function automatic logic fwd_hit(input reg_idx_t r);
        logic em_hit;
        logic wb_hit;
        em_hit = exp_em.valid && exp_em.reg_write && !exp_em.mem_read && exp_em.wr_reg == r;
        wb_hit = exp_wb.valid && exp_wb.reg_write && exp_wb.wr_reg == r;
        return (r != 0) && (em_hit || wb_hit);
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flags(input string name, input flags_t exp, input flags_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected r%0d actual r%0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_valid(input string stage, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("The %s stage shows valid=%b at cycle %0d but should show %b",
                     stage, act, cyc, exp);
        end
    endtask

    task automatic compare_outputs();
        string tag;
        string wtag;
        tag  = $sformatf("cycle %0d %s", cyc, em_op.name());
        wtag = $sformatf("cycle %0d mem_wb", cyc);
        check_valid("EX/MEM", exp_em.valid, ex_mem.valid);
        if (exp_em.valid) begin
            check_word({tag, " alu_result"}, exp_em.alu_result, ex_mem.alu_result);
            check_word({tag, " store_data"}, exp_em.store_data, ex_mem.store_data);
            check_reg({tag, " rr1_reg"}, exp_em.rr1_reg, ex_mem.rr1_reg);
            check_reg({tag, " rr2_reg"}, exp_em.rr2_reg, ex_mem.rr2_reg);
            check_reg({tag, " wr_reg"}, exp_em.wr_reg, ex_mem.wr_reg);
            check_bit({tag, " reg_write"}, exp_em.reg_write, ex_mem.reg_write);
            check_bit({tag, " mem_read"}, exp_em.mem_read, ex_mem.mem_read);
            check_bit({tag, " mem_write"}, exp_em.mem_write, ex_mem.mem_write);
            check_bit({tag, " mem_to_reg"}, exp_em.mem_to_reg, ex_mem.mem_to_reg);
            check_bit({tag, " halt"}, exp_em.halt, ex_mem.halt);
        end
        check_valid("MEM/WB", exp_wb.valid, mem_wb.valid);
        if (exp_wb.valid) begin
            check_word({wtag, " wb_data"}, exp_wb.wb_data, mem_wb.wb_data);
            check_reg({wtag, " wr_reg"}, exp_wb.wr_reg, mem_wb.wr_reg);
            check_bit({wtag, " reg_write"}, exp_wb.reg_write, mem_wb.reg_write);
            check_bit({wtag, " halt"}, exp_wb.halt, mem_wb.halt);
        end
        check_flags($sformatf("cycle %0d flags", cyc), exp_flags, flags);
    endtask

    // Stall cycle with junk on the inputs while expectations stay put
    task automatic hold_cycle();
        logic [95:0] junk;
        junk      = {$random(seed), $random(seed), $random(seed)};
        stall     = 1'b1;
        id_ex     = junk[$bits(id_ex_t)-1:0];
        mem_rdata = $random(seed);
    endtask

    // Issue one random instruction and advance the model by one stage
    task automatic issue_next();
        id_ex_t   ins;
        ex_mem_t  em_next;
        mem_wb_t  wb_next;
        flags_t   fl_next;
        opcode_e  op;
        word_t    a;
        word_t    b;
        word_t    res;
        logic     ovf;
        logic     ld_busy;
        mem_rdata         = $random(seed);          // Only a load takes it
        wb_next.valid     = exp_em.valid;
        wb_next.wr_reg    = exp_em.wr_reg;
        wb_next.wb_data   = exp_em.mem_to_reg ? mem_rdata : exp_em.alu_result;
        wb_next.reg_write = exp_em.reg_write;
        wb_next.halt      = exp_em.halt;
        ld_busy = exp_em.valid && exp_em.mem_read && exp_em.reg_write;
        if (ld_busy && exp_em.wr_reg != 0) begin
            rf_now[exp_em.wr_reg] = mem_rdata;      // Load value known from here on
        end
        op = opcode_e'($unsigned($random(seed)) % `CPU_NUM_OPS);
        ins             = '0;
        ins.valid       = ($random(seed) & 7) != 0; // Occasional bubble
        ins.alu_op      = op;
        ins.rr1_reg     = pick_reg(ld_busy, exp_em.wr_reg);
        ins.rr2_reg     = pick_reg(ld_busy, exp_em.wr_reg);
        ins.wr_reg      = $random(seed) & 3;
        ins.imm_value   = $random(seed);
        ins.alu_src     = op inside {SLL, SRA, ROR, LW, SW, LLB, LHB};
        ins.mem_read    = (op == LW);
        ins.mem_to_reg  = (op == LW);
        ins.mem_write   = (op == SW);
        ins.reg_write   = !(op inside {SW, B, BR, HLT});
        ins.flag_enable = op inside {ADD, SUB, XOR, SLL, SRA, ROR};
        ins.halt        = (op == HLT);
        ins.rr1_data    = rf_dec[ins.rr1_reg];      // Stale value without in-flight writes
        ins.rr2_data    = rf_dec[ins.rr2_reg];
        a = rf_now[ins.rr1_reg];
        b = (fwd_hit(ins.rr2_reg) || !ins.alu_src) ? rf_now[ins.rr2_reg] : ins.imm_value;
        res = model_alu(op, a, b, ovf);
        em_next            = '0;
        em_next.valid      = ins.valid;
        em_next.rr1_reg    = ins.rr1_reg;
        em_next.rr2_reg    = ins.rr2_reg;
        em_next.alu_result = res;
        em_next.store_data = rf_now[ins.rr2_reg];   // Never the immediate
        em_next.wr_reg     = ins.wr_reg;
        em_next.mem_write  = ins.mem_write;
        em_next.mem_to_reg = ins.mem_to_reg;
        em_next.reg_write  = ins.reg_write;
        em_next.halt       = ins.halt;
        em_next.mem_read   = ins.mem_read;
        fl_next = exp_flags;
        if (ins.valid && ins.flag_enable) begin
            fl_next[FLAG_Z] = (res == 0);
            if (op inside {ADD, SUB}) begin
                fl_next[FLAG_V] = ovf;
                fl_next[FLAG_N] = res[15];
            end
        end
        if (exp_wb.valid && exp_wb.reg_write && exp_wb.wr_reg != 0) begin
            rf_dec[exp_wb.wr_reg] = exp_wb.wb_data; // Write-back of the oldest item
        end
        if (ins.valid && ins.reg_write && !ins.mem_read && ins.wr_reg != 0) begin
            rf_now[ins.wr_reg] = res;
        end
        exp_wb    = wb_next;
        exp_em    = em_next;
        exp_flags = fl_next;
        em_op     = op;
        stall     = 1'b0;
        id_ex     = ins;
    endtask

    initial begin
        seed        = 32'h616e;
        stall       = 1'b0;
        mem_rdata   = '0;
        id_ex       = '0;
        id_ex.valid = 1'b1;                          // Reset must still clear the stages
        errors      = 0;
        checks      = 0;
        cyc         = 0;
        exp_em      = '0;
        exp_wb      = '0;
        exp_flags   = '0;
        em_op       = ADD;
        rf_now[0]   = '0;                            // R0 reads as zero
        rf_dec[0]   = '0;
        for (int i = 1; i < 16; i++) begin
            rf_now[i] = $random(seed);
            rf_dec[i] = rf_now[i];
        end
        wait (rst_n === 1'b1);
        @(negedge clk);
        compare_outputs();                           // State straight out of reset
        for (cyc = 1; cyc <= NUM_TESTS; cyc++) begin
            if (($random(seed) & 7) == 0) begin
                hold_cycle();
            end else begin
                issue_next();
            end
            @(negedge clk);
            compare_outputs();
        end
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/alu_arith.sv
verilog/alu_shift.sv
verilog/forward_unit.sv
verilog/execute.sv
verilog/mem_wb_stage.sv
verilog/ex_pipeline.sv
bench/tb_clock.sv
bench/tb_ex_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run the bench, then search the log for the pass line
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ex_pipeline -f filelist.f \
    -Mdir obj_dir -o sim_ex_pipeline && ./obj_dir/sim_ex_pipeline > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "SIMULATION PASSED" sim.log && echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }
